// ==== rtl/mdio_pkg.sv ====
/* MDIO frame definitions
   Clause-22 frame constants, the frame word layout and controller states */
`default_nettype none

package mdio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths and frame constants
	//////////////////////////////////////////////////////////////////////

	localparam int MDIO_REG_W         = 5;
	localparam int MDIO_PHY_W         = 5;
	localparam int MDIO_DATA_W        = 16;
	localparam int MDIO_PREAMBLE_BITS = 64;

	// Bit counter spans the preamble, which is the longest phase
	localparam int MDIO_CNT_W = $clog2(MDIO_PREAMBLE_BITS);

	localparam logic [1:0] MDIO_START    = 2'b01;
	localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
	localparam logic [1:0] MDIO_OP_READ  = 2'b10;
	localparam logic [1:0] MDIO_TA_WRITE = 2'b10;
	localparam logic [1:0] MDIO_TA_IDLE  = 2'b11;

	//////////////////////////////////////////////////////////////////////
	// Frame word
	//////////////////////////////////////////////////////////////////////

	// Address half of a frame is sent start bits first
	typedef struct packed {
		logic [1:0]            start;
		logic [1:0]            op;
		logic [MDIO_PHY_W-1:0] phy;
		logic [MDIO_REG_W-1:0] regad;
		logic [1:0]            ta;
	} mdio_header_t;

	typedef union packed {
		mdio_header_t           hdr;
		logic [MDIO_DATA_W-1:0] raw;
	} mdio_word_u;

	typedef enum logic [2:0] {
		ST_RESET,
		ST_IDLE,
		ST_ADDRESS,
		ST_READ,
		ST_WRITE
	} mdio_state_e;

endpackage

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
/* Host register bus types
   Pipelined request and response with stall and acknowledge */
`default_nettype none

package bus_pkg;

	localparam int BUS_ADDR_W = 5;
	localparam int BUS_DATA_W = 16;

	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [BUS_ADDR_W-1:0] addr;
		logic [BUS_DATA_W-1:0] data;
	} bus_req_t;

	// Data holds the last word read from the PHY
	typedef struct packed {
		logic                  ack;
		logic                  stall;
		logic [BUS_DATA_W-1:0] data;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/mdio_clkgen.sv ====
/* MDC clock divider
   Divides i_clk by 2^CLKBITS and strobes the bit tick ahead of each MDC fall */
`timescale 1ns/1ns
`default_nettype none

module mdio_clkgen #(
	parameter int CLKBITS = 2
) (
	input  logic i_clk,
	input  logic i_reset,
	output logic o_mdc,
	output logic o_tick
);

	logic [CLKBITS-1:0] count;
	logic [CLKBITS-1:0] count_next;

	assign count_next = count + 1'b1;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			count  <= '0;
			o_tick <= 1'b0;
		end
		else
		begin
			count  <= count_next;
			// High while the count sits at all ones just before MDC falls
			o_tick <= &count_next;
		end
	end

	assign o_mdc = count[CLKBITS-1];

endmodule

`default_nettype wire

// ==== rtl/mdio_shifter.sv ====
/* MDIO shift datapath
   Serializes frame words onto the data line and collects read data */
`timescale 1ns/1ns
`default_nettype none

module mdio_shifter (
	input  logic                             i_clk,
	input  logic                             i_reset,
	input  logic                             i_tick,
	input  logic                             i_load,
	input  mdio_pkg::mdio_word_u             i_load_word,
	input  logic                             i_capture,
	input  logic                             i_mdio,
	output logic                             o_mdio,
	output logic [mdio_pkg::MDIO_DATA_W-1:0] o_rd_data
);
	import mdio_pkg::*;

	logic [MDIO_DATA_W-1:0] tx_word;
	logic [MDIO_DATA_W-1:0] rx_word;

	//////////////////////////////////////////////////////////////////////
	// Transmit
	//////////////////////////////////////////////////////////////////////

	// Ones fill in behind the shifted bits so the line idles high
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			tx_word <= '1;
			o_mdio  <= 1'b1;
		end
		else
		begin
			if (i_tick)
				o_mdio <= tx_word[MDIO_DATA_W-1];

			if (i_load)
				tx_word <= i_load_word.raw;
			else if (i_tick)
				tx_word <= {tx_word[MDIO_DATA_W-2:0], 1'b1};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Receive
	//////////////////////////////////////////////////////////////////////

	// PHY data arrives MSB first
	always_ff @(posedge i_clk)
	begin
		if (i_tick && i_capture)
			rx_word <= {rx_word[MDIO_DATA_W-2:0], i_mdio};
	end

	assign o_rd_data = rx_word;

endmodule

`default_nettype wire

// ==== rtl/mdio_ctrl.sv ====
/* MDIO frame controller
   Sequences preamble and clause-22 frames, handles bus stall and acknowledge */
`timescale 1ns/1ns
`default_nettype none

module mdio_ctrl #(
	parameter logic [mdio_pkg::MDIO_PHY_W-1:0] PHY_ADDR = 5'd1
) (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_tick,
	input  bus_pkg::bus_req_t    i_req,
	output logic                 o_ack,
	output logic                 o_stall,
	output logic                 o_mdwe,
	output logic                 o_load,
	output mdio_pkg::mdio_word_u o_load_word,
	output logic                 o_capture
);
	import mdio_pkg::*;

	mdio_state_e            state;
	logic [MDIO_CNT_W-1:0]  bit_cnt;
	logic                   r_we;
	logic [MDIO_DATA_W-1:0] r_data;
	logic                   pending_ack;
	logic                   accept;
	logic                   last_bit;

	assign accept   = i_req.stb && !o_stall;
	assign last_bit = i_tick && (bit_cnt == '0);
	assign o_stall  = (state != ST_IDLE);

	// No PHY bit is valid yet at the first data tick
	assign o_capture = (state == ST_READ) && (bit_cnt != MDIO_CNT_W'(MDIO_DATA_W));

	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			r_we   <= i_req.we;
			r_data <= i_req.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shift register loads
	//////////////////////////////////////////////////////////////////////

	// Header is built straight from the request so it is ready by the next tick
	always_comb
	begin
		o_load          = accept || ((state == ST_ADDRESS) && last_bit);
		o_load_word.raw = r_we ? r_data : '1;
		if (state == ST_IDLE)
		begin
			o_load_word.hdr.start = MDIO_START;
			o_load_word.hdr.op    = i_req.we ? MDIO_OP_WRITE : MDIO_OP_READ;
			o_load_word.hdr.phy   = PHY_ADDR;
			o_load_word.hdr.regad = i_req.addr;
			o_load_word.hdr.ta    = i_req.we ? MDIO_TA_WRITE : MDIO_TA_IDLE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state   <= ST_RESET;
			bit_cnt <= MDIO_CNT_W'(MDIO_PREAMBLE_BITS - 1);
			o_mdwe  <= 1'b1;
		end
		else
		begin
			if (i_tick && (bit_cnt != '0))
				bit_cnt <= bit_cnt - 1'b1;

			case (state)
			ST_RESET:
				if (last_bit)
					state <= ST_IDLE;
			ST_IDLE:
				if (accept)
				begin
					state   <= ST_ADDRESS;
					bit_cnt <= MDIO_CNT_W'(MDIO_DATA_W - 1);
				end
			ST_ADDRESS:
			begin
				// Let go of the line for both turnaround bits of a read
				if (i_tick && (bit_cnt == MDIO_CNT_W'(1)) && !r_we)
					o_mdwe <= 1'b0;
				if (last_bit)
				begin
					state   <= r_we ? ST_WRITE : ST_READ;
					bit_cnt <= MDIO_CNT_W'(MDIO_DATA_W);
				end
			end
			ST_READ, ST_WRITE:
				if (last_bit)
				begin
					state  <= ST_IDLE;
					o_mdwe <= 1'b1;
				end
			default:
				state <= ST_RESET;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Acknowledge
	//////////////////////////////////////////////////////////////////////

	// An abandoned cycle loses its ack while the frame still runs out
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_req.cyc)
			pending_ack <= 1'b0;
		else if (accept)
			pending_ack <= 1'b1;
		else if (o_ack)
			pending_ack <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ack <= 1'b0;
		else
			o_ack <= last_bit && pending_ack && i_req.cyc
				&& ((state == ST_READ) || (state == ST_WRITE));
	end

endmodule

`default_nettype wire

// ==== rtl/mdio_top.sv ====
/* MDIO master top level
   Bus-controlled station management master for an Ethernet PHY */
`timescale 1ns/1ns
`default_nettype none

module mdio_top #(
	parameter int                              CLKBITS  = 2,
	parameter logic [mdio_pkg::MDIO_PHY_W-1:0] PHY_ADDR = 5'd1
) (
	input  logic              i_clk,
	input  logic              i_reset,
	input  bus_pkg::bus_req_t i_bus_req,
	output bus_pkg::bus_rsp_t o_bus_rsp,
	output logic              o_mdc,
	output logic              o_mdio,
	output logic              o_mdwe,
	input  logic              i_mdio
);
	import mdio_pkg::*;

	logic                   tick;
	logic                   load;
	mdio_word_u             load_word;
	logic                   capture;
	logic                   ack;
	logic                   stall;
	logic [MDIO_DATA_W-1:0] rd_data;

	mdio_ctrl #(
		.PHY_ADDR (PHY_ADDR)
	) ctrl_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_tick      (tick),
		.i_req       (i_bus_req),
		.o_ack       (ack),
		.o_stall     (stall),
		.o_mdwe      (o_mdwe),
		.o_load      (load),
		.o_load_word (load_word),
		.o_capture   (capture)
	);

	mdio_clkgen #(
		.CLKBITS (CLKBITS)
	) clkgen_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.o_mdc   (o_mdc),
		.o_tick  (tick)
	);

	mdio_shifter shifter_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_tick      (tick),
		.i_load      (load),
		.i_load_word (load_word),
		.i_capture   (capture),
		.i_mdio      (i_mdio),
		.o_mdio      (o_mdio),
		.o_rd_data   (rd_data)
	);

	assign o_bus_rsp = '{ack: ack, stall: stall, data: rd_data};

endmodule

`default_nettype wire

// ==== testbench/mdio_phy_model.sv ====
/* Behavioral MDIO PHY
   Decodes clause-22 frames, holds 32 registers and answers read frames */
`timescale 1ns/1ns
`default_nettype none

module mdio_phy_model (
	input  logic i_mdc,
	input  logic i_mdio,
	input  logic i_mdwe,
	output logic o_mdio
);
	import mdio_pkg::*;

	logic [MDIO_DATA_W-1:0] regs [0:31];
	logic [31:0]            shreg;
	logic                   in_frame;
	int                     nbits;
	int                     frame_count;
	int                     ones_count;
	int                     mdwe_high;
	logic [1:0]             last_start;
	logic [1:0]             last_op;
	logic [1:0]             last_ta;
	logic [4:0]             last_phy;
	logic [4:0]             last_reg;
	logic [15:0]            last_data;

	// Register contents at power up
	function automatic logic [15:0] reset_value(input logic [4:0] addr);
		return {addr, 3'b101, ~addr, 3'b010};
	endfunction

	// Turnaround is two falling edges, then data goes out MSB first
	task automatic answer_read(input logic [4:0] addr);
		logic [15:0] word;
		word = regs[addr];
		repeat (2) @(negedge i_mdc);
		for (int i = 15; i >= 0; i--)
		begin
			@(negedge i_mdc);
			o_mdio = word[i];
			@(posedge i_mdc);
			if (i_mdwe)
				mdwe_high++;
		end
		@(negedge i_mdc);
		o_mdio = 1'b1;
		frame_count++;
	endtask

	initial
	begin
		for (int i = 0; i < 32; i++)
			regs[i] = reset_value(5'(i));
		o_mdio      = 1'b1;
		shreg       = '0;
		in_frame    = 1'b0;
		nbits       = 0;
		frame_count = 0;
		ones_count  = 0;
		mdwe_high   = 0;
		forever
		begin
			@(posedge i_mdc);
			if (i_mdwe && !in_frame)
			begin
				// Hunt for the zero that opens the start pattern
				if (i_mdio)
					ones_count++;
				else
				begin
					in_frame = 1'b1;
					shreg    = '0;
					nbits    = 1;
				end
			end
			else if (i_mdwe)
			begin
				shreg = {shreg[30:0], i_mdio};
				nbits++;
				if (nbits == 14)
				begin
					last_start = shreg[13:12];
					last_op    = shreg[11:10];
					last_phy   = shreg[9:5];
					last_reg   = shreg[4:0];
					if (last_op == MDIO_OP_READ)
					begin
						in_frame = 1'b0;
						answer_read(last_reg);
					end
					else if (last_op != MDIO_OP_WRITE)
						in_frame = 1'b0;
				end
				else if (nbits == 32)
				begin
					last_ta         = shreg[17:16];
					last_data       = shreg[15:0];
					regs[last_reg]  = last_data;
					frame_count++;
					in_frame = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_mdio.sv ====
/* MDIO master testbench
   Runs preamble, write, read, back-pressure and dropped-cycle frames */
`timescale 1ns/1ns
`default_nettype none

module tb_mdio;
	import bus_pkg::*;

	localparam int CLKBITS        = 2;
	localparam int TIMEOUT_CYCLES = 40 * 40 * (1 << CLKBITS);

	typedef struct packed {
		logic        is_read;
		logic [15:0] data;
	} expect_t;

	logic        clk;
	logic        reset;
	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic        mdc;
	logic        mdio_out;
	logic        mdwe;
	logic        mdio_in;
	logic [15:0] ref_regs [0:31];
	expect_t     exp_q [$];
	expect_t     entry;
	int          exp_idx;
	int          ack_count;
	int          accepted;
	int          cycle_count;
	integer      seed;
	logic [31:0] rnd;

	mdio_top #(
		.CLKBITS  (CLKBITS),
		.PHY_ADDR (5'd1)
	) dut_i (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_bus_req (bus_req),
		.o_bus_rsp (bus_rsp),
		.o_mdc     (mdc),
		.o_mdio    (mdio_out),
		.o_mdwe    (mdwe),
		.i_mdio    (mdio_in)
	);

	mdio_phy_model phy_i (
		.i_mdc  (mdc),
		.i_mdio (mdio_out),
		.i_mdwe (mdwe),
		.o_mdio (mdio_in)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			abort_run();
		end
	endtask

	// Expected register contents after each access
	function automatic logic [15:0] ref_access(input logic we, input logic [4:0] addr,
			input logic [15:0] data);
		if (we)
			ref_regs[addr] = data;
		return ref_regs[addr];
	endfunction

	task automatic bus_access(input logic we, input logic [4:0] addr, input logic [15:0] data,
			input int hold_stb, input logic drop_cyc);
		int          acks_before;
		int          frames_before;
		logic [15:0] expv;
		acks_before   = ack_count;
		frames_before = phy_i.frame_count;
		expv          = ref_access(we, addr, data);
		while (bus_rsp.stall)
			@(negedge clk);
		if (!drop_cyc)
			exp_q.push_back('{is_read: !we, data: expv});
		@(posedge clk);
		#2;
		bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, data: data};
		@(posedge clk);
		accepted++;
		// Extra stb cycles land while stall is high
		repeat (hold_stb) @(posedge clk);
		#2;
		bus_req.stb = 1'b0;
		if (drop_cyc)
		begin
			repeat (3) @(posedge clk);
			#2;
			bus_req.cyc = 1'b0;
			while (phy_i.frame_count == frames_before || bus_rsp.stall)
				@(negedge clk);
			repeat (3) @(posedge clk);
			check("ack count", 32'(ack_count), 32'(acks_before));
		end
		else
		begin
			while (ack_count == acks_before)
				@(posedge clk);
			#2;
			bus_req.cyc = 1'b0;
			repeat (3) @(posedge clk);
			check("ack count", 32'(ack_count), 32'(acks_before + 1));
		end
		check("frame count", 32'(phy_i.frame_count), 32'(accepted));
		check("start", 32'(phy_i.last_start), 32'(2'b01));
		check("opcode", 32'(phy_i.last_op), we ? 32'(2'b01) : 32'(2'b10));
		check("phy address", 32'(phy_i.last_phy), 32'(5'd1));
		check("register address", 32'(phy_i.last_reg), 32'(addr));
		if (we)
		begin
			check("turnaround", 32'(phy_i.last_ta), 32'(2'b10));
			check("write data", 32'(phy_i.last_data), 32'(data));
		end
		else
			check("o_mdwe high in read data", 32'(phy_i.mdwe_high), 32'(0));
	endtask

	// Compare every acknowledge against the queued expectation
	always @(negedge clk)
	begin
		if (!reset && bus_rsp.ack)
		begin
			if (exp_idx >= exp_q.size())
			begin
				$display("Error: acknowledge at %0t ns with no request waiting for one", $time);
				abort_run();
			end
			else
			begin
				entry = exp_q[exp_idx];
				if (entry.is_read)
					check("o_bus_rsp.data", 32'(bus_rsp.data), 32'(entry.data));
				exp_idx++;
				ack_count++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	initial
	begin
		seed        = 79;
		bus_req     = '0;
		reset       = 1'b1;
		exp_idx     = 0;
		ack_count   = 0;
		accepted    = 0;
		cycle_count = 0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = {5'(i), 3'b101, ~5'(i), 3'b010};
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		//////////////////////////////////////////////////////////////////////
		// Reset and preamble
		//////////////////////////////////////////////////////////////////////
		@(negedge clk);
		check("o_bus_rsp.stall", 32'(bus_rsp.stall), 32'(1));
		check("o_bus_rsp.ack", 32'(bus_rsp.ack), 32'(0));
		while (bus_rsp.stall)
			@(negedge clk);
		if (phy_i.ones_count < 32)
		begin
			$display("Error: only %0d preamble ones seen before the bus became ready",
				phy_i.ones_count);
			abort_run();
		end

		//////////////////////////////////////////////////////////////////////
		// Directed frames
		//////////////////////////////////////////////////////////////////////
		bus_access(1'b1, 5'h03, 16'hbeef, 0, 1'b0);
		bus_access(1'b0, 5'h07, 16'h0000, 0, 1'b0);
		bus_access(1'b0, 5'h03, 16'h0000, 0, 1'b0);
		// stb held high through the stall
		bus_access(1'b1, 5'h0c, 16'h5aa5, 20, 1'b0);
		// Abandoned cycle still writes the register
		bus_access(1'b1, 5'h09, 16'h1234, 0, 1'b1);
		bus_access(1'b0, 5'h09, 16'h0000, 0, 1'b0);

		// Random mix on a few registers so reads hit earlier writes
		for (int n = 0; n < 30; n++)
		begin
			rnd = $random(seed);
			bus_access(rnd[31], {2'b00, rnd[18:16]}, rnd[15:0], 0, 1'b0);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/mdio_pkg.sv
rtl/bus_pkg.sv
rtl/mdio_clkgen.sv
rtl/mdio_shifter.sv
rtl/mdio_ctrl.sv
rtl/mdio_top.sv
testbench/mdio_phy_model.sv
testbench/tb_mdio.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the MDIO master simulation with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_mdio -o tb_mdio
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mdio > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if ! grep -q "Test OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
